/* compile.f */
hw/msg_pkg.sv
hw/chk_pkg.sv
hw/pak_index_counter.sv
hw/msg_source.sv
hw/pak_serializer.sv
hw/pak_deserializer.sv
hw/sink_checker_fsm.sv
hw/pakout_top.sv
verif/pakout_sva.sv
verif/pakout_tb.sv

/* hw/chk_pkg.sv */
package chk_pkg;

	// Checker walks one state per rule after taking a message
	typedef enum logic [1:0] {
		chk_idle,
		chk_src,
		chk_seq,
		chk_red
	} chk_state_t;

	// Received message counter
	localparam int rcv_cnt_w = 16;

endpackage

/* hw/msg_pkg.sv */
package msg_pkg;

	// Field widths of one test message
	localparam int msg_addr_w = 4;
	localparam int msg_data_w = 8;
	localparam int msg_red_w = 4;
	localparam int msg_w = msg_red_w + msg_data_w + 2 * msg_addr_w;

	// Packet layout on the wire
	localparam int pak_w = 5;
	localparam int pak_cnt = msg_w / pak_w;

	// Field order from MSB down
	typedef struct packed {
		logic [msg_red_w-1:0] red;
		logic [msg_data_w-1:0] dat;
		logic [msg_addr_w-1:0] dst;
		logic [msg_addr_w-1:0] src;
	} msg_fields_t;

	// Same 20-bit word seen as fields or as packets
	// paks[0] is the low slice, sent first
	typedef union packed {
		msg_fields_t fields;
		logic [pak_cnt-1:0][pak_w-1:0] paks;
	} msg_word_t;

	// Redundancy nibble over addresses and both data nibbles
	function automatic logic [msg_red_w-1:0] msg_redun(
		input logic [msg_addr_w-1:0] src,
		input logic [msg_addr_w-1:0] dst,
		input logic [msg_data_w-1:0] dat
	);
		logic [msg_red_w-1:0] lo_nib;
		logic [msg_red_w-1:0] hi_nib;
		lo_nib = dat[msg_red_w-1:0];
		hi_nib = dat[msg_data_w-1:msg_red_w];
		return src ^ dst ^ lo_nib ^ hi_nib;
	endfunction

endpackage

/* hw/msg_source.sv */
`timescale 1ns/1ps

module msg_source #(
	parameter logic [msg_pkg::msg_addr_w-1:0] MIN_ADDR = 4'd1,
	parameter logic [msg_pkg::msg_addr_w-1:0] MAX_ADDR = 4'd3,
	parameter logic [msg_pkg::msg_addr_w-1:0] SRC_ADDR = 4'd3
) (
	input  logic                i_clk,
	input  logic                rst_n,
	output logic                msg_valid,
	output msg_pkg::msg_word_t  msg,
	input  logic                msg_ready
);

	logic [msg_pkg::msg_addr_w-1:0] dst;
	logic [msg_pkg::msg_data_w-1:0] dat;
	logic                           xfer;

	assign xfer = msg_valid && msg_ready;

	always_ff @(posedge i_clk or negedge rst_n) begin
		if (!rst_n) begin
			msg_valid <= 1'b0;
			dst <= MIN_ADDR;
			dat <= '0;
		end else begin
			// Always has a message ready once out of reset
			msg_valid <= 1'b1;
			if (xfer) begin
				dat <= dat + 1'b1;
				// Destination cycles MIN_ADDR .. MAX_ADDR
				if (dst >= MAX_ADDR) begin
					dst <= MIN_ADDR;
				end else begin
					dst <= dst + 1'b1;
				end
			end
		end
	end

	// Build the word through its field view
	always_comb begin
		msg.fields.src = SRC_ADDR;
		msg.fields.dst = dst;
		msg.fields.dat = dat;
		msg.fields.red = msg_pkg::msg_redun(SRC_ADDR, dst, dat);
	end

endmodule

/* hw/pak_deserializer.sv */
`timescale 1ns/1ps

module pak_deserializer (
	input  logic                       i_clk,
	input  logic                       rst_n,
	input  logic                       pak_valid,
	input  logic [msg_pkg::pak_w-1:0]  pak,
	output logic                       pak_ready,
	output logic                       msg_valid,
	output msg_pkg::msg_word_t         msg,
	input  logic                       msg_ready
);

	msg_pkg::msg_word_t                   msg_q;
	logic [$clog2(msg_pkg::pak_cnt)-1:0]  idx;
	logic                                 last;
	logic                                 pak_xfer;
	logic                                 held;

	// Input blocked while a complete message waits
	assign pak_ready = !held;
	assign pak_xfer = pak_valid && pak_ready;
	assign msg_valid = held;
	assign msg = msg_q;

	pak_index_counter #(
		.COUNT(msg_pkg::pak_cnt)
	) u_idx (
		.i_clk  (i_clk),
		.rst_n  (rst_n),
		.advance(pak_xfer),
		.idx    (idx),
		.last   (last)
	);

	always_ff @(posedge i_clk or negedge rst_n) begin
		if (!rst_n) begin
			held <= 1'b0;
		end else if (pak_xfer && last) begin
			held <= 1'b1;
		end else if (msg_valid && msg_ready) begin
			held <= 1'b0;
		end
	end

	// Packet 0 fills the low slice
	always_ff @(posedge i_clk) begin
		if (pak_xfer) begin
			msg_q.paks[idx] <= pak;
		end
	end

endmodule

/* hw/pak_index_counter.sv */
`timescale 1ns/1ps

module pak_index_counter #(
	parameter int COUNT = 4,
	localparam int IDX_W = (COUNT > 1) ? $clog2(COUNT) : 1
) (
	input  logic             i_clk,
	input  logic             rst_n,
	input  logic             advance,
	output logic [IDX_W-1:0] idx,
	output logic             last
);

	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(COUNT - 1);

	// Final packet of the message
	assign last = (idx == LAST_IDX);

	always_ff @(posedge i_clk or negedge rst_n) begin
		if (!rst_n) begin
			idx <= '0;
		end else if (advance) begin
			// Wrap so the next message starts at packet 0
			if (last) begin
				idx <= '0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

endmodule

/* hw/pak_serializer.sv */
`timescale 1ns/1ps

module pak_serializer (
	input  logic                       i_clk,
	input  logic                       rst_n,
	input  logic                       msg_valid,
	input  msg_pkg::msg_word_t         msg,
	output logic                       msg_ready,
	output logic                       pak_valid,
	output logic [msg_pkg::pak_w-1:0]  pak,
	input  logic                       pak_ready
);

	logic                                 full;
	msg_pkg::msg_word_t                   msg_q;
	logic [$clog2(msg_pkg::pak_cnt)-1:0]  idx;
	logic                                 last;
	logic                                 pak_xfer;

	// One message in flight at a time
	assign msg_ready = !full;
	assign pak_valid = full;
	assign pak = msg_q.paks[idx];
	assign pak_xfer = pak_valid && pak_ready;

	pak_index_counter #(
		.COUNT(msg_pkg::pak_cnt)
	) u_idx (
		.i_clk  (i_clk),
		.rst_n  (rst_n),
		.advance(pak_xfer),
		.idx    (idx),
		.last   (last)
	);

	always_ff @(posedge i_clk or negedge rst_n) begin
		if (!rst_n) begin
			full <= 1'b0;
		end else if (msg_valid && msg_ready) begin
			full <= 1'b1;
		end else if (pak_xfer && last) begin
			// Last packet gone, free for the next message
			full <= 1'b0;
		end
	end

	// Payload holds while stalled
	always_ff @(posedge i_clk) begin
		if (msg_valid && msg_ready) begin
			msg_q <= msg;
		end
	end

endmodule

/* hw/pakout_top.sv */
`timescale 1ns/1ps

module pakout_top #(
	parameter logic [msg_pkg::msg_addr_w-1:0] MIN_ADDR = 4'd1,
	parameter logic [msg_pkg::msg_addr_w-1:0] MAX_ADDR = 4'd3,
	parameter logic [msg_pkg::msg_addr_w-1:0] SRC_ADDR = 4'd3
) (
	input  logic                            i_clk,
	input  logic                            rst_n,
	output logic                            pak_out_valid,
	output logic [msg_pkg::pak_w-1:0]       pak_out,
	input  logic                            pak_out_ready,
	input  logic                            pak_in_valid,
	input  logic [msg_pkg::pak_w-1:0]       pak_in,
	output logic                            pak_in_ready,
	output logic                            err_src,
	output logic                            err_seq,
	output logic                            err_red,
	output logic [msg_pkg::msg_addr_w-1:0]  bad_src_info,
	output logic [msg_pkg::msg_addr_w-1:0]  bad_seq_dst_info,
	output logic [chk_pkg::rcv_cnt_w-1:0]   rcv_count
);

	// Source chain
	logic               src_msg_valid;
	msg_pkg::msg_word_t src_msg;
	logic               src_msg_ready;

	// Sink chain
	logic               rx_msg_valid;
	msg_pkg::msg_word_t rx_msg;
	logic               rx_msg_ready;

	msg_source #(
		.MIN_ADDR(MIN_ADDR),
		.MAX_ADDR(MAX_ADDR),
		.SRC_ADDR(SRC_ADDR)
	) u_source (
		.i_clk    (i_clk),
		.rst_n    (rst_n),
		.msg_valid(src_msg_valid),
		.msg      (src_msg),
		.msg_ready(src_msg_ready)
	);

	pak_serializer u_ser (
		.i_clk    (i_clk),
		.rst_n    (rst_n),
		.msg_valid(src_msg_valid),
		.msg      (src_msg),
		.msg_ready(src_msg_ready),
		.pak_valid(pak_out_valid),
		.pak      (pak_out),
		.pak_ready(pak_out_ready)
	);

	pak_deserializer u_deser (
		.i_clk    (i_clk),
		.rst_n    (rst_n),
		.pak_valid(pak_in_valid),
		.pak      (pak_in),
		.pak_ready(pak_in_ready),
		.msg_valid(rx_msg_valid),
		.msg      (rx_msg),
		.msg_ready(rx_msg_ready)
	);

	sink_checker_fsm #(
		.SRC_ADDR(SRC_ADDR)
	) u_chk (
		.i_clk           (i_clk),
		.rst_n           (rst_n),
		.msg_valid       (rx_msg_valid),
		.msg             (rx_msg),
		.msg_ready       (rx_msg_ready),
		.err_src         (err_src),
		.err_seq         (err_seq),
		.err_red         (err_red),
		.bad_src_info    (bad_src_info),
		.bad_seq_dst_info(bad_seq_dst_info),
		.rcv_count       (rcv_count)
	);

endmodule

/* hw/sink_checker_fsm.sv */
`timescale 1ns/1ps

module sink_checker_fsm #(
	parameter logic [msg_pkg::msg_addr_w-1:0] SRC_ADDR = 4'd3
) (
	input  logic                            i_clk,
	input  logic                            rst_n,
	input  logic                            msg_valid,
	input  msg_pkg::msg_word_t              msg,
	output logic                            msg_ready,
	output logic                            err_src,
	output logic                            err_seq,
	output logic                            err_red,
	output logic [msg_pkg::msg_addr_w-1:0]  bad_src_info,
	output logic [msg_pkg::msg_addr_w-1:0]  bad_seq_dst_info,
	output logic [chk_pkg::rcv_cnt_w-1:0]   rcv_count
);

	chk_pkg::chk_state_t             state;
	msg_pkg::msg_word_t              cur;
	logic [msg_pkg::msg_data_w-1:0]  prev_dat;
	logic                            have_prev;

	assign msg_ready = (state == chk_pkg::chk_idle);

	// Message under check
	always_ff @(posedge i_clk) begin
		if (msg_valid && msg_ready) begin
			cur <= msg;
		end
	end

	always_ff @(posedge i_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= chk_pkg::chk_idle;
			err_src <= 1'b0;
			err_seq <= 1'b0;
			err_red <= 1'b0;
			bad_src_info <= '0;
			bad_seq_dst_info <= '0;
			rcv_count <= '0;
			prev_dat <= '0;
			have_prev <= 1'b0;
		end else begin
			case (state)
				chk_pkg::chk_idle: begin
					if (msg_valid) begin
						state <= chk_pkg::chk_src;
					end
				end
				chk_pkg::chk_src: begin
					// Flags and info keep their first hit
					if (!err_src && cur.fields.src != SRC_ADDR) begin
						err_src <= 1'b1;
						bad_src_info <= cur.fields.src;
					end
					state <= chk_pkg::chk_seq;
				end
				chk_pkg::chk_seq: begin
					if (have_prev && !err_seq && cur.fields.dat != prev_dat + 1'b1) begin
						err_seq <= 1'b1;
						bad_seq_dst_info <= cur.fields.dst;
					end
					// Resync on every message, good or bad
					prev_dat <= cur.fields.dat;
					have_prev <= 1'b1;
					state <= chk_pkg::chk_red;
				end
				default: begin
					if (cur.fields.red != msg_pkg::msg_redun(cur.fields.src, cur.fields.dst,
							cur.fields.dat)) begin
						err_red <= 1'b1;
					end
					rcv_count <= rcv_count + 1'b1;
					state <= chk_pkg::chk_idle;
				end
			endcase
		end
	end

endmodule

/* verif/pakout_sva.sv */
`timescale 1ns/1ps

module pakout_sva (
	input  logic                       i_clk,
	input  logic                       rst_n,
	input  logic                       pak_out_valid,
	input  logic [msg_pkg::pak_w-1:0]  pak_out,
	input  logic                       pak_out_ready,
	input  logic                       pak_in_valid,
	input  logic [msg_pkg::pak_w-1:0]  pak_in,
	input  logic                       pak_in_ready,
	input  logic                       rx_msg_valid
);

	localparam int CNT_W = $clog2(msg_pkg::pak_cnt);
	localparam logic [CNT_W-1:0] LAST_PAK = CNT_W'(msg_pkg::pak_cnt - 1);

	// Packets taken on pak_in within the current message
	logic [CNT_W-1:0] in_cnt;

	always_ff @(posedge i_clk or negedge rst_n) begin
		if (!rst_n) begin
			in_cnt <= '0;
		end else if (pak_in_valid && pak_in_ready) begin
			if (in_cnt == LAST_PAK) begin
				in_cnt <= '0;
			end else begin
				in_cnt <= in_cnt + 1'b1;
			end
		end
	end

	// A stalled packet holds until it is taken
	out_hold: assert property (@(posedge i_clk) disable iff (!rst_n)
		pak_out_valid && !pak_out_ready |=> pak_out_valid && $stable(pak_out))
		else $error("pak_out dropped or changed while stalled");

	in_hold: assert property (@(posedge i_clk) disable iff (!rst_n)
		pak_in_valid && !pak_in_ready |=> pak_in_valid && $stable(pak_in))
		else $error("pak_in dropped or changed while stalled");

	// Last packet completes the message and blocks further input
	in_block: assert property (@(posedge i_clk) disable iff (!rst_n)
		pak_in_valid && pak_in_ready && in_cnt == LAST_PAK
		|=> rx_msg_valid && !pak_in_ready)
		else $error("no held message or pak_in_ready high after the last packet");

endmodule

/* verif/pakout_tb.sv */
`timescale 1ns/1ps

module pakout_tb;

	localparam logic [3:0] MIN_ADDR = 4'd1;
	localparam logic [3:0] MAX_ADDR = 4'd3;
	localparam logic [3:0] SRC_ADDR = 4'd3;
	// 24 messages of a few dozen cycles each, with ample margin
	localparam int MAX_CYCLES = 4000;

	logic                                  i_clk = 1'b0;
	logic                                  rst_n;
	logic                                  pak_out_valid;
	logic [msg_pkg::pak_w-1:0]             pak_out;
	logic                                  pak_out_ready;
	logic                                  pak_in_valid;
	logic [msg_pkg::pak_w-1:0]             pak_in;
	logic                                  pak_in_ready;
	logic                                  err_src;
	logic                                  err_seq;
	logic                                  err_red;
	logic [msg_pkg::msg_addr_w-1:0]        bad_src_info;
	logic [msg_pkg::msg_addr_w-1:0]        bad_seq_dst_info;
	logic [chk_pkg::rcv_cnt_w-1:0]         rcv_count;

	// Reference model state
	logic [3:0]                            exp_dst;
	logic [7:0]                            exp_dat;
	logic [7:0]                            last_dat;
	int                                    exp_rcv;
	int                                    fail_cnt = 0;
	int                                    cycles = 0;

	pakout_top #(
		.MIN_ADDR(MIN_ADDR),
		.MAX_ADDR(MAX_ADDR),
		.SRC_ADDR(SRC_ADDR)
	) DUT (.*);

	bind pakout_top pakout_sva u_sva (.*);

	always #50 i_clk = ~i_clk;

	always @(posedge i_clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			abort_run("Timeout: the tests did not finish within the cycle limit");
		end
	end

	task automatic abort_run(input string why);
		fail_cnt++;
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp) else begin
			abort_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	task automatic check_flags(input logic s, input logic q, input logic r);
		check_val("err_src", err_src, s);
		check_val("err_seq", err_seq, q);
		check_val("err_red", err_red, r);
		check_val("rcv_count", rcv_count, exp_rcv);
	endtask

	// XOR of both addresses and both data nibbles
	function automatic logic [3:0] calc_red(input msg_pkg::msg_fields_t f);
		return f.src ^ f.dst ^ f.dat[3:0] ^ f.dat[7:4];
	endfunction

	function automatic msg_pkg::msg_word_t make_msg(input logic [3:0] src,
			input logic [3:0] dst, input logic [7:0] dat, input logic [3:0] red_flip);
		msg_pkg::msg_word_t w;
		w.fields.src = src;
		w.fields.dst = dst;
		w.fields.dat = dat;
		w.fields.red = calc_red(w.fields) ^ red_flip;
		return w;
	endfunction

	// Called on a falling edge, samples pak_out while it is stable
	task automatic collect_msg(input bit rnd, output msg_pkg::msg_word_t w);
		int n;
		logic rdy;
		n = 0;
		while (n < msg_pkg::pak_cnt) begin
			rdy = rnd ? 1'($urandom) : 1'b1;
			pak_out_ready = rdy;
			if (pak_out_valid && rdy) begin
				w.paks[n] = pak_out;
				n++;
			end
			@(negedge i_clk);
		end
		pak_out_ready = 1'b0;
	endtask

	task automatic check_source_msg(input msg_pkg::msg_word_t w);
		check_val("src", w.fields.src, SRC_ADDR);
		check_val("dst", w.fields.dst, exp_dst);
		check_val("dat", w.fields.dat, exp_dat);
		check_val("red", w.fields.red, calc_red(w.fields));
		exp_dst = (exp_dst == MAX_ADDR) ? MIN_ADDR : exp_dst + 4'd1;
		exp_dat = exp_dat + 8'd1;
	endtask

	// Packet 0 first, each one only once pak_in_ready is seen high
	task automatic send_msg(input msg_pkg::msg_word_t w);
		for (int i = 0; i < msg_pkg::pak_cnt; i++) begin
			while (!pak_in_ready) begin
				pak_in_valid = 1'b0;
				@(negedge i_clk);
			end
			pak_in_valid = 1'b1;
			pak_in = w.paks[i];
			@(negedge i_clk);
		end
		pak_in_valid = 1'b0;
		// Checker is done once rcv_count moves
		while (rcv_count == exp_rcv) begin
			@(negedge i_clk);
		end
		exp_rcv++;
		last_dat = w.fields.dat;
	endtask

	task automatic test_reset();
		check_val("pak_out_valid", pak_out_valid, 1'b0);
		check_val("pak_in_ready", pak_in_ready, 1'b1);
		check_flags(1'b0, 1'b0, 1'b0);
	endtask

	task automatic test_source(input bit rnd, input int count);
		msg_pkg::msg_word_t w;
		repeat (count) begin
			collect_msg(rnd, w);
			check_source_msg(w);
		end
	endtask

	task automatic test_loopback();
		msg_pkg::msg_word_t w;
		repeat (4) begin
			collect_msg(1'b0, w);
			check_source_msg(w);
			send_msg(w);
			check_flags(1'b0, 1'b0, 1'b0);
		end
	endtask

	task automatic test_bad_msgs();
		send_msg(make_msg(4'd5, MIN_ADDR, last_dat + 8'd1, 4'h0));
		check_flags(1'b1, 1'b0, 1'b0);
		check_val("bad_src_info", bad_src_info, 4'd5);
		// Skips one data value
		send_msg(make_msg(SRC_ADDR, 4'd2, last_dat + 8'd2, 4'h0));
		check_flags(1'b1, 1'b1, 1'b0);
		check_val("bad_seq_dst_info", bad_seq_dst_info, 4'd2);
		send_msg(make_msg(SRC_ADDR, 4'd3, last_dat + 8'd1, 4'h6));
		check_flags(1'b1, 1'b1, 1'b1);
		// Clean message leaves every flag and info as it was
		send_msg(make_msg(SRC_ADDR, MIN_ADDR, last_dat + 8'd1, 4'h0));
		check_flags(1'b1, 1'b1, 1'b1);
		check_val("bad_src_info", bad_src_info, 4'd5);
		check_val("bad_seq_dst_info", bad_seq_dst_info, 4'd2);
	endtask

	initial begin
		void'($urandom(32'h25c6_c3d4));
		rst_n = 1'b0;
		pak_out_ready = 1'b0;
		pak_in_valid = 1'b0;
		pak_in = '0;
		exp_dst = MIN_ADDR;
		exp_dat = 8'd0;
		last_dat = 8'd0;
		exp_rcv = 0;
		repeat (3) @(posedge i_clk);
		@(negedge i_clk);
		rst_n = 1'b1;
		test_reset();
		test_source(1'b0, 8);
		test_source(1'b1, 8);
		test_loopback();
		test_bad_msgs();
		if (fail_cnt == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule
